// ==== Bender.yml ====
package:
  name: wasm_interp

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/wasm_pkg.sv
      - rtl/code_rom.sv
      - rtl/leb128_decoder.sv
      - rtl/insn_fetch.sv
      - rtl/value_stack.sv
      - rtl/insn_exec.sv
      - rtl/wasm_core.sv
  - target: test
    files:
      - verif/wasm_clock_gen.sv
      - verif/wasm_checker.sv
      - verif/wasm_tb.sv

// ==== rtl/code_rom.sv ====
`include "wasm_params.svh"

`default_nettype none

module code_rom
  import wasm_pkg::*;
(
  input  logic                        clk,
  input  logic                        load_en,
  input  code_addr_t                  load_addr,
  input  logic [7:0]                  load_data,
  input  code_addr_t                  rd_addr,
  output logic [`WINDOW_BYTES*8-1:0]  window
);

  logic [7:0] mem [`CODE_BYTES];

  // Program load port
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // Byte 0 of the window lands in the low bits
  always_ff @(posedge clk) begin
    for (int i = 0; i < `WINDOW_BYTES; i++) begin
      // Address arithmetic wraps at the end of memory
      window[8*i +: 8] <= mem[code_addr_t'(rd_addr + i)];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/insn_exec.sv ====
`include "wasm_params.svh"

`default_nettype none

module insn_exec
  import wasm_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         insn_valid,
  input  insn_t        insn,
  input  stack_entry_t tos,
  input  stack_entry_t nos,
  input  stack_entry_t third,
  input  stack_cnt_t   count,
  output stack_req_t   req,
  output logic         insn_retire,
  output trap_e        trap
);

  insn_t        insn_q;
  logic         pending;
  logic         known;
  logic         pushes;
  logic         types_ok;
  stack_cnt_t   need;
  trap_e        stop;
  trap_e        fault;
  stack_op_e    op_sel;
  stack_entry_t res;

  function automatic stack_entry_t i32_entry(input logic [31:0] v);
    stack_entry_t e;
    e.tag   = I32;
    e.value = {32'd0, v};
    return e;
  endfunction

  always_ff @(posedge clk) begin
    if (insn_valid) begin
      insn_q <= insn;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else begin
      pending <= insn_valid && (trap == TRAP_NONE);
    end
  end

  // Decode operand needs and the result
  always_comb begin
    known    = 1'b1;
    pushes   = 1'b0;
    types_ok = 1'b1;
    need     = '0;
    stop     = TRAP_NONE;
    op_sel   = NONE;
    res      = tos;
    case (insn_q.opcode)
      OP_UNREACHABLE: stop = TRAP_UNREACHABLE;
      OP_NOP: ;
      OP_END:         stop = TRAP_ENDED;
      OP_DROP: begin
        need   = stack_cnt_t'(1);
        op_sel = POP;
      end
      OP_SELECT: begin
        // Condition on top, b second, a third
        need     = stack_cnt_t'(3);
        types_ok = (tos.tag == I32) && (nos.tag == third.tag);
        op_sel   = POP2_REPLACE;
        res      = (tos.value[31:0] != 32'd0) ? third : nos;
      end
      OP_I32_CONST: begin
        pushes = 1'b1;
        op_sel = PUSH;
        res    = i32_entry(insn_q.imm[31:0]);
      end
      OP_I64_CONST: begin
        pushes    = 1'b1;
        op_sel    = PUSH;
        res.tag   = I64;
        res.value = insn_q.imm;
      end
      OP_I32_EQZ, OP_I64_EQZ: begin
        need     = stack_cnt_t'(1);
        op_sel   = REPLACE;
        if (insn_q.opcode == OP_I32_EQZ) begin
          types_ok = (tos.tag == I32);
          res      = i32_entry({31'd0, tos.value[31:0] == 32'd0});
        end else begin
          types_ok = (tos.tag == I64);
          res      = i32_entry({31'd0, tos.value == 64'd0});
        end
      end
      OP_I32_EQ:  res = i32_entry({31'd0, nos.value[31:0] == tos.value[31:0]});
      OP_I32_NE:  res = i32_entry({31'd0, nos.value[31:0] != tos.value[31:0]});
      OP_I64_EQ:  res = i32_entry({31'd0, nos.value == tos.value});
      OP_I64_NE:  res = i32_entry({31'd0, nos.value != tos.value});
      OP_I32_ADD: res = i32_entry(nos.value[31:0] + tos.value[31:0]);
      OP_I32_SUB: res = i32_entry(nos.value[31:0] - tos.value[31:0]);
      OP_I64_ADD: begin
        res.tag   = I64;
        res.value = nos.value + tos.value;
      end
      OP_I64_SUB: begin
        res.tag   = I64;
        res.value = nos.value - tos.value;
      end
      default: known = 1'b0;
    endcase
    // Binary ops share operand count and stack op
    case (insn_q.opcode)
      OP_I32_EQ, OP_I32_NE, OP_I32_ADD, OP_I32_SUB: begin
        need     = stack_cnt_t'(2);
        op_sel   = POP_REPLACE;
        types_ok = (tos.tag == I32) && (nos.tag == I32);
      end
      OP_I64_EQ, OP_I64_NE, OP_I64_ADD, OP_I64_SUB: begin
        need     = stack_cnt_t'(2);
        op_sel   = POP_REPLACE;
        types_ok = (tos.tag == I64) && (nos.tag == I64);
      end
      default: ;
    endcase
  end

  // Checks in priority order
  always_comb begin
    if (!known) begin
      fault = TRAP_UNKNOWN_OPCODE;
    end else if (stop != TRAP_NONE) begin
      fault = stop;
    end else if (count < need) begin
      fault = TRAP_STACK_EMPTY;
    end else if (pushes && (count == stack_cnt_t'(`STACK_DEPTH))) begin
      fault = TRAP_STACK_OVERFLOW;
    end else if (!types_ok) begin
      fault = TRAP_TYPE_MISMATCH;
    end else begin
      fault = TRAP_NONE;
    end
  end

  assign insn_retire = pending && (fault == TRAP_NONE);
  assign req.op      = insn_retire ? op_sel : NONE;
  assign req.entry   = res;

  // First trap sticks until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      trap <= TRAP_NONE;
    end else if (pending && (fault != TRAP_NONE)) begin
      trap <= fault;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/insn_fetch.sv ====
`include "wasm_params.svh"

`default_nettype none

module insn_fetch
  import wasm_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  code_addr_t                 start_pc,
  output code_addr_t                 rd_addr,
  input  logic [`WINDOW_BYTES*8-1:0] window,
  output logic                       insn_valid,
  output insn_t                      insn,
  input  logic                       insn_retire
);

  typedef enum logic [1:0] {
    ISSUE,
    DECODE,
    WAIT
  } fetch_state_e;

  fetch_state_e state;
  code_addr_t   pc;
  opcode_e      opcode;
  value_t       imm;
  logic [3:0]   imm_len;
  logic         has_imm;

  // Immediate starts right after the opcode byte
  leb128_decoder u_leb (
    .bytes  (window[`WINDOW_BYTES*8-1:8]),
    .value  (imm),
    .length (imm_len)
  );

  assign opcode  = opcode_e'(window[7:0]);
  assign has_imm = (opcode == OP_I32_CONST) || (opcode == OP_I64_CONST);

  assign rd_addr     = pc;
  assign insn_valid  = (state == DECODE);
  assign insn.opcode = opcode;
  assign insn.imm    = imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ISSUE;
      pc    <= start_pc;
    end else begin
      case (state)
        // Window for the current PC arrives next cycle
        ISSUE: state <= DECODE;
        DECODE: begin
          state <= WAIT;
          if (has_imm) begin
            pc <= pc + code_addr_t'(imm_len) + code_addr_t'(1);
          end else begin
            pc <= pc + code_addr_t'(1);
          end
        end
        // Held here for good once a trap is raised
        WAIT: begin
          if (insn_retire) begin
            state <= ISSUE;
          end
        end
        default: state <= ISSUE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/leb128_decoder.sv ====
`default_nettype none

module leb128_decoder
  import wasm_pkg::*;
(
  input  logic [79:0] bytes,
  output value_t      value,
  output logic [3:0]  length
);

  logic done;

  always_comb begin
    value  = '0;
    length = 4'd10;
    done   = 1'b0;
    for (int i = 0; i < 10; i++) begin
      if (!done) begin
        // Seven payload bits per byte, least significant group first
        value = value | (value_t'(bytes[8*i +: 7]) << (7*i));
        if (!bytes[8*i+7]) begin
          done   = 1'b1;
          length = 4'(i + 1);
          // Sign bit of the last group fills the upper bits
          if (bytes[8*i+6] && (7*(i+1) < 64)) begin
            value = value | ({64{1'b1}} << (7*(i+1)));
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/value_stack.sv ====
`include "wasm_params.svh"

`default_nettype none

module value_stack
  import wasm_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  stack_req_t   req,
  output stack_entry_t tos,
  output stack_entry_t nos,
  output stack_entry_t third,
  output stack_cnt_t   count
);

  localparam int IDX_W = $clog2(`STACK_DEPTH);

  stack_entry_t     entries [`STACK_DEPTH];
  logic [IDX_W-1:0] idx0;
  logic [IDX_W-1:0] idx1;
  logic [IDX_W-1:0] idx2;
  logic [IDX_W-1:0] idx3;

  // Free slot, then top, second and third entries
  assign idx0 = IDX_W'(count);
  assign idx1 = IDX_W'(count - stack_cnt_t'(1));
  assign idx2 = IDX_W'(count - stack_cnt_t'(2));
  assign idx3 = IDX_W'(count - stack_cnt_t'(3));

  assign tos   = entries[idx1];
  assign nos   = entries[idx2];
  assign third = entries[idx3];

  always_ff @(posedge clk) begin
    case (req.op)
      PUSH:         entries[idx0] <= req.entry;
      REPLACE:      entries[idx1] <= req.entry;
      POP_REPLACE:  entries[idx2] <= req.entry;
      POP2_REPLACE: entries[idx3] <= req.entry;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case (req.op)
        PUSH:              count <= count + stack_cnt_t'(1);
        POP, POP_REPLACE:  count <= count - stack_cnt_t'(1);
        POP2_REPLACE:      count <= count - stack_cnt_t'(2);
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wasm_core.sv ====
`include "wasm_params.svh"

`default_nettype none

module wasm_core
  import wasm_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  code_addr_t   start_pc,
  input  logic         load_en,
  input  code_addr_t   load_addr,
  input  logic [7:0]   load_data,
  output stack_entry_t result,
  output logic         result_empty,
  output trap_e        trap
);

  code_addr_t                 rd_addr;
  logic [`WINDOW_BYTES*8-1:0] window;
  logic                       insn_valid;
  logic                       insn_retire;
  insn_t                      insn;
  stack_req_t                 req;
  stack_entry_t               nos;
  stack_entry_t               third;
  stack_cnt_t                 count;

  assign result_empty = (count == '0);

  code_rom u_rom (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_addr   (rd_addr),
    .window    (window)
  );

  insn_fetch u_fetch (
    .clk         (clk),
    .reset       (reset),
    .start_pc    (start_pc),
    .rd_addr     (rd_addr),
    .window      (window),
    .insn_valid  (insn_valid),
    .insn        (insn),
    .insn_retire (insn_retire)
  );

  // Top of stack doubles as the visible result
  value_stack u_stack (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .tos   (result),
    .nos   (nos),
    .third (third),
    .count (count)
  );

  insn_exec u_exec (
    .clk         (clk),
    .reset       (reset),
    .insn_valid  (insn_valid),
    .insn        (insn),
    .tos         (result),
    .nos         (nos),
    .third       (third),
    .count       (count),
    .req         (req),
    .insn_retire (insn_retire),
    .trap        (trap)
  );

endmodule

`default_nettype wire

// ==== rtl/wasm_params.svh ====
`ifndef WASM_PARAMS_SVH
`define WASM_PARAMS_SVH

// Entries in the value stack
`define STACK_DEPTH 8

// Code memory size in bytes, and the matching address width
`define CODE_BYTES 64
`define CODE_ADDR_W 6

// One opcode byte plus the longest 64-bit LEB128 immediate
`define WINDOW_BYTES 11

`endif

// ==== rtl/wasm_pkg.sv ====
`include "wasm_params.svh"

`default_nettype none

package wasm_pkg;

  typedef logic [`CODE_ADDR_W-1:0] code_addr_t;
  typedef logic [3:0] stack_cnt_t;
  typedef logic [63:0] value_t;

  typedef enum logic [1:0] {
    I32 = 2'd0,
    I64 = 2'd1
  } val_type_e;

  // i32 values sit zero-extended in the low half
  typedef struct packed {
    val_type_e tag;
    value_t    value;
  } stack_entry_t;

  // WebAssembly encodings of the supported opcodes
  typedef enum logic [7:0] {
    OP_UNREACHABLE = 8'h00,
    OP_NOP         = 8'h01,
    OP_END         = 8'h0B,
    OP_DROP        = 8'h1A,
    OP_SELECT      = 8'h1B,
    OP_I32_CONST   = 8'h41,
    OP_I64_CONST   = 8'h42,
    OP_I32_EQZ     = 8'h45,
    OP_I32_EQ      = 8'h46,
    OP_I32_NE      = 8'h47,
    OP_I64_EQZ     = 8'h50,
    OP_I64_EQ      = 8'h51,
    OP_I64_NE      = 8'h52,
    OP_I32_ADD     = 8'h6A,
    OP_I32_SUB     = 8'h6B,
    OP_I64_ADD     = 8'h7C,
    OP_I64_SUB     = 8'h7D
  } opcode_e;

  typedef enum logic [3:0] {
    TRAP_NONE           = 4'd0,
    TRAP_ENDED          = 4'd1,
    TRAP_UNREACHABLE    = 4'd2,
    TRAP_UNKNOWN_OPCODE = 4'd3,
    TRAP_STACK_EMPTY    = 4'd4,
    TRAP_STACK_OVERFLOW = 4'd5,
    TRAP_TYPE_MISMATCH  = 4'd6
  } trap_e;

  // Compound ops pop first, then overwrite the new top
  typedef enum logic [2:0] {
    NONE         = 3'd0,
    PUSH         = 3'd1,
    POP          = 3'd2,
    REPLACE      = 3'd3,
    POP_REPLACE  = 3'd4,
    POP2_REPLACE = 3'd5
  } stack_op_e;

  typedef struct packed {
    opcode_e opcode;
    value_t  imm;
  } insn_t;

  typedef struct packed {
    stack_op_e    op;
    stack_entry_t entry;
  } stack_req_t;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/wasm_pkg.sv
rtl/code_rom.sv
rtl/leb128_decoder.sv
rtl/insn_fetch.sv
rtl/value_stack.sv
rtl/insn_exec.sv
rtl/wasm_core.sv
verif/wasm_clock_gen.sv
verif/wasm_checker.sv
verif/wasm_tb.sv

// ==== verif/wasm_checker.sv ====
`include "wasm_params.svh"

`default_nettype none

module wasm_checker
  import wasm_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input trap_e      trap,
  input logic       insn_valid,
  input logic       insn_retire,
  input stack_cnt_t count
);

  // A raised trap is sticky until the next reset
  trap_sticky: assert property (
    @(posedge clk) disable iff (reset)
    (trap != TRAP_NONE) |=> $stable(trap)
  ) else $error("trap changed before reset");

  // Execute answers only an instruction it was given
  retire_after_valid: assert property (
    @(posedge clk) disable iff (reset)
    insn_retire |-> $past(insn_valid)
  ) else $error("insn_retire without a preceding insn_valid");

  stack_bounded: assert property (
    @(posedge clk) disable iff (reset)
    count <= stack_cnt_t'(`STACK_DEPTH)
  ) else $error("stack count above depth");

  strobes_apart: assert property (
    @(posedge clk) disable iff (reset)
    !(insn_valid && insn_retire)
  ) else $error("insn_valid and insn_retire high together");

endmodule

`default_nettype wire

// ==== verif/wasm_clock_gen.sv ====
`default_nettype none

module wasm_clock_gen (
  output logic clk
);

  // Period of 4 time units
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== verif/wasm_tb.sv ====
`default_nettype none

module wasm_tb
  import wasm_pkg::*;
();

  localparam int PROG_BYTES = 20;
  localparam int TIMEOUT    = 200;

  // One program with its expected outcome
  typedef struct packed {
    logic [0:PROG_BYTES-1][7:0] prog;
    code_addr_t                 start_pc;
    trap_e                      exp_trap;
    logic                       exp_empty;
    val_type_e                  exp_tag;
    value_t                     exp_value;
  } row_t;

  logic         clk;
  logic         reset;
  code_addr_t   start_pc;
  logic         load_en;
  code_addr_t   load_addr;
  logic [7:0]   load_data;
  stack_entry_t result;
  logic         result_empty;
  trap_e        trap;

  row_t                       rows [32];
  int                         n_rows;
  int                         seed;
  int                         pass_count;
  int                         fail_count;
  logic [0:PROG_BYTES-1][7:0] build;
  int                         build_len;

  wasm_clock_gen u_clk (
    .clk (clk)
  );

  wasm_core dut (
    .clk          (clk),
    .reset        (reset),
    .start_pc     (start_pc),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .result       (result),
    .result_empty (result_empty),
    .trap         (trap)
  );

  bind wasm_core wasm_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .trap        (trap),
    .insn_valid  (insn_valid),
    .insn_retire (insn_retire),
    .count       (count)
  );

  // Program bytes are given right-aligned, len says how many are used
  task automatic add_row(input logic [8*PROG_BYTES-1:0] code, input int len,
                         input code_addr_t pc, input trap_e t, input logic empty,
                         input val_type_e tag, input value_t val);
    row_t r;
    r.prog      = code << (8 * (PROG_BYTES - len));
    r.start_pc  = pc;
    r.exp_trap  = t;
    r.exp_empty = empty;
    r.exp_tag   = tag;
    r.exp_value = val;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic emit(input logic [7:0] b);
    build[build_len] = b;
    build_len++;
  endtask

  // Signed LEB128 encoding of a 32-bit value
  task automatic emit_leb(input logic [31:0] v);
    logic signed [31:0] rest;
    logic [7:0]         group;
    logic               more;
    rest = v;
    more = 1'b1;
    while (more) begin
      group = {1'b0, rest[6:0]};
      rest  = rest >>> 7;
      more  = !(((rest == 0) && !group[6]) || ((rest == -1) && group[6]));
      emit(more ? (group | 8'h80) : group);
    end
  endtask

  task automatic add_binop_row(input logic [31:0] a, input logic [31:0] b,
                               input logic [7:0] op, input logic [31:0] expect_val);
    build     = '0;
    build_len = 0;
    emit(8'h41);
    emit_leb(a);
    emit(8'h41);
    emit_leb(b);
    emit(op);
    emit(8'h0B);
    add_row(build, PROG_BYTES, '0, TRAP_ENDED, 1'b0, I32, {32'd0, expect_val});
  endtask

  task automatic add_random_rows();
    logic [31:0] ra;
    logic [31:0] rb;
    ra = $random(seed);
    rb = $random(seed);
    add_binop_row(ra, rb, 8'h6A, ra + rb);
    add_binop_row(ra, rb, 8'h6B, ra - rb);
  endtask

  task automatic fill_table();
    // Constants and arithmetic
    add_row({8'h41, 8'h05, 8'h41, 8'hAC, 8'h02, 8'h6A, 8'h0B}, 7, '0, TRAP_ENDED, 1'b0,
            I32, 64'd305);
    add_row({8'h41, 8'h00, 8'h41, 8'h01, 8'h6B, 8'h0B}, 6, '0, TRAP_ENDED, 1'b0,
            I32, 64'h0000_0000_FFFF_FFFF);
    add_row({8'h41, 8'hB8, 8'h7E, 8'h0B}, 4, '0, TRAP_ENDED, 1'b0,
            I32, 64'h0000_0000_FFFF_FF38);
    add_row({8'h42, 8'h80, 8'h80, 8'h80, 8'h80, 8'h10, 8'h42, 8'h7F, 8'h7C, 8'h0B}, 10, '0,
            TRAP_ENDED, 1'b0, I64, 64'h0000_0000_FFFF_FFFF);
    add_row({8'h42, 8'h00, 8'h42, 8'h01, 8'h7D, 8'h0B}, 6, '0, TRAP_ENDED, 1'b0,
            I64, 64'hFFFF_FFFF_FFFF_FFFF);
    add_row({8'h41, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'h07, 8'h41, 8'h01, 8'h6A, 8'h0B}, 10, '0,
            TRAP_ENDED, 1'b0, I32, 64'h0000_0000_8000_0000);
    // Comparisons
    add_row({8'h41, 8'h05, 8'h41, 8'h05, 8'h46, 8'h0B}, 6, '0, TRAP_ENDED, 1'b0, I32, 64'd1);
    add_row({8'h41, 8'h05, 8'h41, 8'h06, 8'h46, 8'h0B}, 6, '0, TRAP_ENDED, 1'b0, I32, 64'd0);
    add_row({8'h41, 8'h05, 8'h41, 8'h06, 8'h47, 8'h0B}, 6, '0, TRAP_ENDED, 1'b0, I32, 64'd1);
    add_row({8'h41, 8'h00, 8'h45, 8'h0B}, 4, '0, TRAP_ENDED, 1'b0, I32, 64'd1);
    add_row({8'h42, 8'h05, 8'h50, 8'h0B}, 4, '0, TRAP_ENDED, 1'b0, I32, 64'd0);
    add_row({8'h42, 8'h7F, 8'h42, 8'h7F, 8'h51, 8'h0B}, 6, '0, TRAP_ENDED, 1'b0, I32, 64'd1);
    add_row({8'h42, 8'h01, 8'h42, 8'h02, 8'h52, 8'h0B}, 6, '0, TRAP_ENDED, 1'b0, I32, 64'd1);
    // drop and select
    add_row({8'h41, 8'h07, 8'h1A, 8'h0B}, 4, '0, TRAP_ENDED, 1'b1, I32, 64'd0);
    add_row({8'h41, 8'h07, 8'h41, 8'h08, 8'h1A, 8'h0B}, 6, '0, TRAP_ENDED, 1'b0, I32, 64'd7);
    add_row({8'h41, 8'h0A, 8'h41, 8'h14, 8'h41, 8'h01, 8'h1B, 8'h0B}, 8, '0,
            TRAP_ENDED, 1'b0, I32, 64'd10);
    add_row({8'h42, 8'h0A, 8'h42, 8'h14, 8'h41, 8'h00, 8'h1B, 8'h0B}, 8, '0,
            TRAP_ENDED, 1'b0, I64, 64'd20);
    // Type mismatches leave the stack untouched
    add_row({8'h41, 8'h01, 8'h42, 8'h02, 8'h6A, 8'h0B}, 6, '0, TRAP_TYPE_MISMATCH, 1'b0,
            I64, 64'd2);
    add_row({8'h41, 8'h01, 8'h41, 8'h02, 8'h42, 8'h01, 8'h1B, 8'h0B}, 8, '0,
            TRAP_TYPE_MISMATCH, 1'b0, I64, 64'd1);
    add_row({8'h41, 8'h01, 8'h42, 8'h02, 8'h41, 8'h01, 8'h1B, 8'h0B}, 8, '0,
            TRAP_TYPE_MISMATCH, 1'b0, I32, 64'd1);
    // Stack underflow and overflow
    add_row({8'h41, 8'h01, 8'h6A, 8'h0B}, 4, '0, TRAP_STACK_EMPTY, 1'b0, I32, 64'd1);
    add_row({8'h1A, 8'h0B}, 2, '0, TRAP_STACK_EMPTY, 1'b1, I32, 64'd0);
    add_row({8'h41, 8'h01, 8'h41, 8'h02, 8'h41, 8'h03, 8'h41, 8'h04, 8'h41, 8'h05,
             8'h41, 8'h06, 8'h41, 8'h07, 8'h41, 8'h08, 8'h41, 8'h09, 8'h0B}, 19, '0,
            TRAP_STACK_OVERFLOW, 1'b0, I32, 64'd8);
    // Control
    add_row({8'h41, 8'h03, 8'h00, 8'h0B}, 4, '0, TRAP_UNREACHABLE, 1'b0, I32, 64'd3);
    add_row({8'h41, 8'h04, 8'hFF, 8'h0B}, 4, '0, TRAP_UNKNOWN_OPCODE, 1'b0, I32, 64'd4);
    add_row({8'h41, 8'h06, 8'h01, 8'h01, 8'h0B}, 5, '0, TRAP_ENDED, 1'b0, I32, 64'd6);
    add_row({8'h00, 8'h00, 8'h00, 8'h00, 8'h41, 8'h0C, 8'h0B}, 7, code_addr_t'(4),
            TRAP_ENDED, 1'b0, I32, 64'd12);
  endtask

  task automatic run_test(input int idx);
    row_t r;
    int   cycles;
    int   errs;
    r    = rows[idx];
    errs = 0;
    @(negedge clk);
    reset    = 1'b1;
    start_pc = r.start_pc;
    for (int i = 0; i < PROG_BYTES; i++) begin
      load_en   = 1'b1;
      load_addr = code_addr_t'(i);
      load_data = r.prog[i];
      @(negedge clk);
    end
    load_en = 1'b0;
    repeat (3) @(negedge clk);
    reset  = 1'b0;
    cycles = 0;
    while ((trap == TRAP_NONE) && (cycles < TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    assert (trap != TRAP_NONE) else begin
      $display("test %0d: no trap was raised within %0d cycles", idx, TIMEOUT);
      errs++;
    end
    assert (trap == r.exp_trap) else begin
      $display("error: time %0t trap got %0d expected %0d", $time, trap, r.exp_trap);
      errs++;
    end
    assert (result_empty == r.exp_empty) else begin
      $display("error: time %0t result_empty got %0b expected %0b", $time, result_empty,
               r.exp_empty);
      errs++;
    end
    // Top of stack only has meaning when something is on it
    if (!r.exp_empty) begin
      assert (result.tag == r.exp_tag) else begin
        $display("error: time %0t result.tag got %0d expected %0d", $time, result.tag,
                 r.exp_tag);
        errs++;
      end
      assert (result.value == r.exp_value) else begin
        $display("error: time %0t result.value got %h expected %h", $time, result.value,
                 r.exp_value);
        errs++;
      end
    end
    if (errs == 0) begin
      pass_count++;
      $display("test %0d ok", idx);
    end else begin
      fail_count++;
      $display("test %0d failed with %0d errors", idx, errs);
    end
  endtask

  initial begin
    reset      = 1'b1;
    start_pc   = '0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    seed       = 32'h2c76;
    n_rows     = 0;
    pass_count = 0;
    fail_count = 0;
    fill_table();
    add_random_rows();
    for (int i = 0; i < n_rows; i++) begin
      run_test(i);
    end
    $display("passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
